/* design/vid_defines.svh */
`ifndef VID_DEFINES_SVH
`define VID_DEFINES_SVH

// Frame geometry
`define VID_LINE_PIXELS      32
`define VID_NUM_LINES        8
`define VID_WORDS_PER_LINE   8

// Memories
`define VID_RAM_WORDS        256
`define VID_PALETTE_ENTRIES  256

// Register bus address map
`define VID_REG_ADDR_BITS    12
`define VID_RAM_BASE         12'h000
`define VID_RAM_MASK         12'hC00
`define VID_LAYER1_BASE      12'h400
`define VID_LAYER2_BASE      12'h410
`define VID_COMP_BASE        12'h420
`define VID_REGS_MASK        12'hFF0
`define VID_PAL_BASE         12'h600
`define VID_PAL_MASK         12'hE00

// Register offsets inside a block
`define VID_LAYER_CTRL       4'h0
`define VID_LAYER_BASE_OFS   4'h1
`define VID_COMP_CTRL        4'h0

`endif

/* design/regbus_pkg.sv */
`include "vid_defines.svh"

package regbus_pkg;

    // Host register bus
    typedef logic [`VID_REG_ADDR_BITS-1:0] reg_addr_t;
    typedef logic [7:0]                    reg_data_t;

    // Main RAM word bus
    typedef logic [$clog2(`VID_RAM_WORDS)-1:0] ram_addr_t;
    typedef logic [31:0]                       ram_word_t;

    // Decoded address regions
    typedef enum logic [2:0] {
        REGION_RAM,
        REGION_LAYER1,
        REGION_LAYER2,
        REGION_COMPOSER,
        REGION_PALETTE,
        REGION_NONE
    } region_e;

endpackage

/* design/video_pkg.sv */
`include "vid_defines.svh"

package video_pkg;

    // Palette index as stored in RAM and line buffers
    typedef logic [$clog2(`VID_PALETTE_ENTRIES)-1:0] pixel_idx_t;

    // 12-bit colour, red in the top nibble
    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } rgb_t;

    // Position inside a line and line number inside a frame
    typedef logic [$clog2(`VID_LINE_PIXELS)-1:0] line_pos_t;
    typedef logic [$clog2(`VID_NUM_LINES)-1:0]   line_num_t;

endpackage

/* design/dp_ram.sv */
`timescale 1ns/100ps

module dp_ram #(
    parameter type entry_t = logic [7:0],
    parameter int  DEPTH   = 32
) (
    input  logic                     clk,

    // Write port
    input  logic                     wr_en_i,
    input  logic [$clog2(DEPTH)-1:0] wr_addr_i,
    input  entry_t                   wr_data_i,

    // Read port, one cycle latency
    input  logic [$clog2(DEPTH)-1:0] rd_addr_i,
    output entry_t                   rd_data_o
);

    entry_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem[wr_addr_i] <= wr_data_i;
        end
    end

    // Old data is returned on a same-address collision
    always_ff @(posedge clk) begin
        rd_data_o <= mem[rd_addr_i];
    end

endmodule

/* design/mem_arbiter.sv */
`timescale 1ns/100ps

`include "vid_defines.svh"

module mem_arbiter import regbus_pkg::*; (
    input  logic      clk,
    input  logic      reset,

    // Host port, already qualified by the RAM region
    input  logic      host_strobe_i,
    input  logic      host_write_i,
    input  reg_addr_t host_addr_i,
    input  reg_data_t host_wrdata_i,
    output reg_data_t host_rddata_o,

    // Renderer ports
    input  logic      l1_strobe_i,
    input  ram_addr_t l1_addr_i,
    input  logic      l2_strobe_i,
    input  ram_addr_t l2_addr_i,
    output logic      l1_ack_o,
    output logic      l2_ack_o,
    output ram_word_t rd_word_o
);

    localparam int AW = $clog2(`VID_RAM_WORDS);

    ram_addr_t  word_addr;
    logic       l1_grant;
    logic       l2_grant;
    logic [1:0] host_lane_q;

    // Fixed priority: host, then layer 1, then layer 2
    always_comb begin
        l1_grant  = 1'b0;
        l2_grant  = 1'b0;
        word_addr = host_addr_i[AW+1:2];
        if (!host_strobe_i) begin
            if (l1_strobe_i) begin
                l1_grant  = 1'b1;
                word_addr = l1_addr_i;
            end else if (l2_strobe_i) begin
                l2_grant  = 1'b1;
                word_addr = l2_addr_i;
            end
        end
    end

    // One RAM per byte lane so the host can write single bytes
    for (genvar b = 0; b < 4; b++) begin : g_lane
        logic [7:0] mem [`VID_RAM_WORDS];
        logic [7:0] rd_q;

        always_ff @(posedge clk) begin
            if (host_strobe_i && host_write_i && host_addr_i[1:0] == 2'(b)) begin
                mem[word_addr] <= host_wrdata_i;
            end
            rd_q <= mem[word_addr];
        end

        assign rd_word_o[8*b +: 8] = rd_q;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            l1_ack_o <= 1'b0;
            l2_ack_o <= 1'b0;
        end else begin
            l1_ack_o <= l1_grant;
            l2_ack_o <= l2_grant;
        end
    end

    // Byte lane of the last host access
    always_ff @(posedge clk) begin
        if (host_strobe_i) begin
            host_lane_q <= host_addr_i[1:0];
        end
    end

    assign host_rddata_o = rd_word_o[8*host_lane_q +: 8];

    a_one_ack: assert property (@(posedge clk) disable iff (reset)
        !(l1_ack_o && l2_ack_o));

endmodule

/* design/layer_renderer.sv */
`timescale 1ns/100ps

`include "vid_defines.svh"

module layer_renderer import regbus_pkg::*, video_pkg::*; (
    input  logic       clk,
    input  logic       reset,

    // Layer registers
    input  logic [3:0] reg_addr_i,
    input  reg_data_t  reg_wrdata_i,
    input  logic       reg_write_i,
    output reg_data_t  reg_rddata_o,

    // Composer handshake
    input  logic       render_start_i,
    input  line_num_t  line_i,
    output logic       render_done_o,

    // Memory bus
    output logic       mem_strobe_o,
    output ram_addr_t  mem_addr_o,
    input  logic       mem_ack_i,
    input  ram_word_t  mem_word_i,

    // Line buffer write port
    output logic       lb_wr_en_o,
    output line_pos_t  lb_wr_addr_o,
    output pixel_idx_t lb_wr_data_o
);

    localparam int CNT_W = $clog2(`VID_WORDS_PER_LINE) + 1;
    localparam logic [CNT_W-1:0] WORDS = CNT_W'(`VID_WORDS_PER_LINE);

    logic             enable_q;
    ram_addr_t        base_q;
    ram_addr_t        line_addr_q;
    logic             fetch_q;
    logic             clear_q;
    logic             unpack_q;
    logic [CNT_W-1:0] req_cnt_q;
    line_pos_t        pos_q;
    ram_word_t        word_q;
    logic             last_write;

    ////////////////////////////////////////
    // Register file
    ////////////////////////////////////////

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            enable_q     <= 1'b0;
            base_q       <= '0;
            reg_rddata_o <= '0;
        end else begin
            if (reg_write_i && reg_addr_i == `VID_LAYER_CTRL) begin
                enable_q <= reg_wrdata_i[0];
            end
            if (reg_write_i && reg_addr_i == `VID_LAYER_BASE_OFS) begin
                base_q <= reg_wrdata_i;
            end
            // Read data follows the address by one cycle
            case (reg_addr_i)
                `VID_LAYER_CTRL:     reg_rddata_o <= {7'b0, enable_q};
                `VID_LAYER_BASE_OFS: reg_rddata_o <= base_q;
                default:             reg_rddata_o <= '0;
            endcase
        end
    end

    ////////////////////////////////////////
    // Fetch and unpack
    ////////////////////////////////////////

    // Next word is requested while the last byte of the current one is written
    assign mem_strobe_o = fetch_q && req_cnt_q != WORDS && !mem_ack_i &&
                          (!unpack_q || pos_q[1:0] == 2'd3);
    assign mem_addr_o   = ram_addr_t'(line_addr_q + req_cnt_q);

    assign last_write = (clear_q && pos_q == line_pos_t'(`VID_LINE_PIXELS - 1)) ||
                        (unpack_q && pos_q[1:0] == 2'd3 && req_cnt_q == WORDS);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            fetch_q       <= 1'b0;
            clear_q       <= 1'b0;
            unpack_q      <= 1'b0;
            req_cnt_q     <= '0;
            pos_q         <= '0;
            line_addr_q   <= '0;
            render_done_o <= 1'b0;
        end else begin
            render_done_o <= last_write;
            if (render_start_i) begin
                fetch_q     <= enable_q;
                clear_q     <= !enable_q;
                req_cnt_q   <= '0;
                pos_q       <= '0;
                // First word of the line, wrapping around the RAM
                line_addr_q <= ram_addr_t'(base_q + line_i * `VID_WORDS_PER_LINE);
            end
            if (clear_q || unpack_q) begin
                pos_q <= pos_q + 1'b1;
            end
            if (unpack_q && pos_q[1:0] == 2'd3) begin
                unpack_q <= 1'b0;
            end
            // Byte 0 goes straight to the buffer in the ack cycle
            if (mem_ack_i) begin
                req_cnt_q <= req_cnt_q + 1'b1;
                pos_q     <= {req_cnt_q[CNT_W-2:0], 2'b01};
                unpack_q  <= 1'b1;
            end
            if (last_write) begin
                fetch_q <= 1'b0;
                clear_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (mem_ack_i) begin
            word_q <= mem_word_i;
        end
    end

    always_comb begin
        lb_wr_en_o   = clear_q || unpack_q || mem_ack_i;
        lb_wr_addr_o = pos_q;
        lb_wr_data_o = '0;
        if (mem_ack_i) begin
            lb_wr_addr_o = {req_cnt_q[CNT_W-2:0], 2'b00};
            lb_wr_data_o = mem_word_i[7:0];
        end else if (unpack_q) begin
            lb_wr_data_o = word_q[8*pos_q[1:0] +: 8];
        end
    end

    a_strobe_held: assert property (@(posedge clk) disable iff (reset)
        mem_strobe_o |=> mem_ack_i || (mem_strobe_o && $stable(mem_addr_o)));

endmodule

/* design/line_composer.sv */
`timescale 1ns/100ps

`include "vid_defines.svh"

module line_composer import video_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       run_i,

    // Renderer handshake
    output logic       render_start_o,
    output line_num_t  line_o,
    input  logic       l1_done_i,
    input  logic       l2_done_i,

    // Line buffer reads
    output line_pos_t  lb_rd_addr_o,
    input  pixel_idx_t l1_pix_i,
    input  pixel_idx_t l2_pix_i,

    // Palette lookup
    output pixel_idx_t pal_rd_addr_o,
    input  rgb_t       pal_rgb_i,

    // Pixel stream
    output logic       pix_valid_o,
    output rgb_t       pix_rgb_o,
    output logic       frame_start_o
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WAIT,
        ST_READ
    } state_e;

    state_e    state_q;
    line_num_t line_q;
    line_num_t next_line;
    line_pos_t rd_cnt_q;
    logic      seen1_q;
    logic      seen2_q;
    logic      both_done;
    logic      reading;
    logic      last_read;
    logic      valid_q1;
    logic      valid_q2;
    logic      frame_q1;
    logic      frame_q2;

    assign both_done = (seen1_q || l1_done_i) && (seen2_q || l2_done_i);
    assign reading   = state_q == ST_READ;
    assign last_read = reading && rd_cnt_q == line_pos_t'(`VID_LINE_PIXELS - 1);
    assign next_line = (line_q == line_num_t'(`VID_NUM_LINES - 1)) ? '0 : line_q + 1'b1;

    assign line_o       = line_q;
    assign lb_rd_addr_o = rd_cnt_q;

    ////////////////////////////////////////
    // Line sequencing
    ////////////////////////////////////////

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state_q        <= ST_IDLE;
            line_q         <= '0;
            rd_cnt_q       <= '0;
            seen1_q        <= 1'b0;
            seen2_q        <= 1'b0;
            render_start_o <= 1'b0;
        end else begin
            render_start_o <= 1'b0;
            case (state_q)
                ST_IDLE: begin
                    if (run_i) begin
                        render_start_o <= 1'b1;
                        state_q        <= ST_WAIT;
                    end
                end
                ST_WAIT: begin
                    seen1_q <= seen1_q || l1_done_i;
                    seen2_q <= seen2_q || l2_done_i;
                    if (both_done) begin
                        seen1_q  <= 1'b0;
                        seen2_q  <= 1'b0;
                        rd_cnt_q <= '0;
                        state_q  <= ST_READ;
                    end
                end
                default: begin
                    rd_cnt_q <= rd_cnt_q + 1'b1;
                    if (last_read) begin
                        // A stopped composer resumes at the top of a frame
                        if (run_i) begin
                            line_q         <= next_line;
                            render_start_o <= 1'b1;
                            state_q        <= ST_WAIT;
                        end else begin
                            line_q  <= '0;
                            state_q <= ST_IDLE;
                        end
                    end
                end
            endcase
        end
    end

    ////////////////////////////////////////
    // Mix, palette and output pipeline
    ////////////////////////////////////////

    // Index 0 on layer 2 is transparent
    assign pal_rd_addr_o = (l2_pix_i != '0) ? l2_pix_i : l1_pix_i;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            valid_q1      <= 1'b0;
            valid_q2      <= 1'b0;
            frame_q1      <= 1'b0;
            frame_q2      <= 1'b0;
            pix_valid_o   <= 1'b0;
            frame_start_o <= 1'b0;
        end else begin
            valid_q1      <= reading;
            frame_q1      <= reading && line_q == '0 && rd_cnt_q == '0;
            valid_q2      <= valid_q1;
            frame_q2      <= frame_q1;
            pix_valid_o   <= valid_q2;
            frame_start_o <= frame_q2;
        end
    end

    always_ff @(posedge clk) begin
        pix_rgb_o <= pal_rgb_i;
    end

    a_start_gap: assert property (@(posedge clk) disable iff (reset)
        $rose(pix_valid_o) |-> !render_start_o && !$past(render_start_o) &&
                               !$past(render_start_o, 2));

endmodule

/* design/vid_top.sv */
`timescale 1ns/100ps

`include "vid_defines.svh"

module vid_top import regbus_pkg::*, video_pkg::*; (
    input  logic      clk,
    input  logic      reset,

    // Host register bus
    input  reg_addr_t reg_addr_i,
    input  reg_data_t reg_wrdata_i,
    input  logic      reg_strobe_i,
    input  logic      reg_write_i,
    output reg_data_t reg_rddata_o,

    // Pixel stream
    output logic      pix_valid_o,
    output rgb_t      pix_rgb_o,
    output logic      frame_start_o
);

    region_e    region;
    region_e    rd_region_q;
    logic       ram_strobe;
    logic       l1_reg_write;
    logic       l2_reg_write;
    logic       pal_write;
    logic       run_q;
    reg_data_t  pal_lo_q;
    rgb_t       pal_wr_data;

    reg_data_t  ram_rddata;
    reg_data_t  l1_rddata;
    reg_data_t  l2_rddata;

    logic       l1_strobe, l2_strobe;
    ram_addr_t  l1_addr, l2_addr;
    logic       l1_ack, l2_ack;
    ram_word_t  rd_word;

    logic       render_start;
    line_num_t  render_line;
    logic       l1_done, l2_done;

    logic       l1_wr_en, l2_wr_en;
    line_pos_t  l1_wr_addr, l2_wr_addr;
    pixel_idx_t l1_wr_data, l2_wr_data;
    line_pos_t  lb_rd_addr;
    pixel_idx_t l1_pix, l2_pix;
    pixel_idx_t pal_rd_addr;
    rgb_t       pal_rgb;

    ////////////////////////////////////////
    // Register decode
    ////////////////////////////////////////

    always_comb begin
        if ((reg_addr_i & `VID_RAM_MASK) == `VID_RAM_BASE) begin
            region = REGION_RAM;
        end else if ((reg_addr_i & `VID_REGS_MASK) == `VID_LAYER1_BASE) begin
            region = REGION_LAYER1;
        end else if ((reg_addr_i & `VID_REGS_MASK) == `VID_LAYER2_BASE) begin
            region = REGION_LAYER2;
        end else if ((reg_addr_i & `VID_REGS_MASK) == `VID_COMP_BASE) begin
            region = REGION_COMPOSER;
        end else if ((reg_addr_i & `VID_PAL_MASK) == `VID_PAL_BASE) begin
            region = REGION_PALETTE;
        end else begin
            region = REGION_NONE;
        end
    end

    assign ram_strobe   = reg_strobe_i && region == REGION_RAM;
    assign l1_reg_write = reg_strobe_i && reg_write_i && region == REGION_LAYER1;
    assign l2_reg_write = reg_strobe_i && reg_write_i && region == REGION_LAYER2;
    assign pal_write    = reg_strobe_i && reg_write_i && region == REGION_PALETTE &&
                          reg_addr_i[0];

    // Composer run bit and the read region for the data mux
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            run_q       <= 1'b0;
            rd_region_q <= REGION_NONE;
        end else begin
            rd_region_q <= region;
            if (reg_strobe_i && reg_write_i && region == REGION_COMPOSER &&
                reg_addr_i[3:0] == `VID_COMP_CTRL) begin
                run_q <= reg_wrdata_i[0];
            end
        end
    end

    // Green and blue wait here until the red byte arrives
    always_ff @(posedge clk) begin
        if (reg_strobe_i && reg_write_i && region == REGION_PALETTE && !reg_addr_i[0]) begin
            pal_lo_q <= reg_wrdata_i;
        end
    end

    assign pal_wr_data = '{r: reg_wrdata_i[3:0], g: pal_lo_q[7:4], b: pal_lo_q[3:0]};

    always_comb begin
        case (rd_region_q)
            REGION_RAM:    reg_rddata_o = ram_rddata;
            REGION_LAYER1: reg_rddata_o = l1_rddata;
            REGION_LAYER2: reg_rddata_o = l2_rddata;
            default:       reg_rddata_o = '0;
        endcase
    end

    ////////////////////////////////////////
    // Memory and renderers
    ////////////////////////////////////////

    mem_arbiter u_mem_arbiter (
        .clk           (clk),
        .reset         (reset),
        .host_strobe_i (ram_strobe),
        .host_write_i  (reg_write_i),
        .host_addr_i   (reg_addr_i),
        .host_wrdata_i (reg_wrdata_i),
        .host_rddata_o (ram_rddata),
        .l1_strobe_i   (l1_strobe),
        .l1_addr_i     (l1_addr),
        .l2_strobe_i   (l2_strobe),
        .l2_addr_i     (l2_addr),
        .l1_ack_o      (l1_ack),
        .l2_ack_o      (l2_ack),
        .rd_word_o     (rd_word)
    );

    layer_renderer u_layer1 (
        .clk            (clk),
        .reset          (reset),
        .reg_addr_i     (reg_addr_i[3:0]),
        .reg_wrdata_i   (reg_wrdata_i),
        .reg_write_i    (l1_reg_write),
        .reg_rddata_o   (l1_rddata),
        .render_start_i (render_start),
        .line_i         (render_line),
        .render_done_o  (l1_done),
        .mem_strobe_o   (l1_strobe),
        .mem_addr_o     (l1_addr),
        .mem_ack_i      (l1_ack),
        .mem_word_i     (rd_word),
        .lb_wr_en_o     (l1_wr_en),
        .lb_wr_addr_o   (l1_wr_addr),
        .lb_wr_data_o   (l1_wr_data)
    );

    layer_renderer u_layer2 (
        .clk            (clk),
        .reset          (reset),
        .reg_addr_i     (reg_addr_i[3:0]),
        .reg_wrdata_i   (reg_wrdata_i),
        .reg_write_i    (l2_reg_write),
        .reg_rddata_o   (l2_rddata),
        .render_start_i (render_start),
        .line_i         (render_line),
        .render_done_o  (l2_done),
        .mem_strobe_o   (l2_strobe),
        .mem_addr_o     (l2_addr),
        .mem_ack_i      (l2_ack),
        .mem_word_i     (rd_word),
        .lb_wr_en_o     (l2_wr_en),
        .lb_wr_addr_o   (l2_wr_addr),
        .lb_wr_data_o   (l2_wr_data)
    );

    ////////////////////////////////////////
    // Line buffers, palette, composer
    ////////////////////////////////////////

    dp_ram #(.entry_t(pixel_idx_t), .DEPTH(`VID_LINE_PIXELS)) u_l1_buf (
        .clk       (clk),
        .wr_en_i   (l1_wr_en),
        .wr_addr_i (l1_wr_addr),
        .wr_data_i (l1_wr_data),
        .rd_addr_i (lb_rd_addr),
        .rd_data_o (l1_pix)
    );

    dp_ram #(.entry_t(pixel_idx_t), .DEPTH(`VID_LINE_PIXELS)) u_l2_buf (
        .clk       (clk),
        .wr_en_i   (l2_wr_en),
        .wr_addr_i (l2_wr_addr),
        .wr_data_i (l2_wr_data),
        .rd_addr_i (lb_rd_addr),
        .rd_data_o (l2_pix)
    );

    dp_ram #(.entry_t(rgb_t), .DEPTH(`VID_PALETTE_ENTRIES)) u_palette (
        .clk       (clk),
        .wr_en_i   (pal_write),
        .wr_addr_i (reg_addr_i[8:1]),
        .wr_data_i (pal_wr_data),
        .rd_addr_i (pal_rd_addr),
        .rd_data_o (pal_rgb)
    );

    line_composer u_composer (
        .clk            (clk),
        .reset          (reset),
        .run_i          (run_q),
        .render_start_o (render_start),
        .line_o         (render_line),
        .l1_done_i      (l1_done),
        .l2_done_i      (l2_done),
        .lb_rd_addr_o   (lb_rd_addr),
        .l1_pix_i       (l1_pix),
        .l2_pix_i       (l2_pix),
        .pal_rd_addr_o  (pal_rd_addr),
        .pal_rgb_i      (pal_rgb),
        .pix_valid_o    (pix_valid_o),
        .pix_rgb_o      (pix_rgb_o),
        .frame_start_o  (frame_start_o)
    );

endmodule

/* dv/vid_model.svh */
`ifndef VID_MODEL_SVH
`define VID_MODEL_SVH

// Mirror of the state that host writes set up
logic [7:0]  model_ram [4*`VID_RAM_WORDS];
logic        model_en [2];
logic [7:0]  model_base [2];
logic [11:0] model_pal [`VID_PALETTE_ENTRIES];
logic [7:0]  model_pal_lo;

function automatic void model_write(input logic [11:0] addr, input logic [7:0] data);
    if (addr < 12'h400) begin
        model_ram[addr[9:0]] = data;
    end else if (addr >= 12'h400 && addr < 12'h420) begin
        // Layer 1 at 0x400, layer 2 at 0x410
        if (addr[3:0] == 4'h0) begin
            model_en[addr[4]] = data[0];
        end else if (addr[3:0] == 4'h1) begin
            model_base[addr[4]] = data;
        end
    end else if (addr >= 12'h600 && addr < 12'h800) begin
        // Even byte holds green and blue, odd byte completes the entry with red
        if (!addr[0]) begin
            model_pal_lo = data;
        end else begin
            model_pal[addr[8:1]] = {data[3:0], model_pal_lo};
        end
    end
endfunction

function automatic logic [7:0] model_read(input logic [11:0] addr);
    logic [7:0] value;
    value = 8'h00;
    if (addr < 12'h400) begin
        value = model_ram[addr[9:0]];
    end else if (addr >= 12'h400 && addr < 12'h420) begin
        if (addr[3:0] == 4'h0) begin
            value = {7'b0, model_en[addr[4]]};
        end else if (addr[3:0] == 4'h1) begin
            value = model_base[addr[4]];
        end
    end
    return value;
endfunction

// Palette index of one layer at a given line and pixel
function automatic logic [7:0] layer_index(input int layer, input int line, input int x);
    int word;
    if (!model_en[layer]) begin
        return 8'h00;
    end
    word = (int'(model_base[layer]) + line * `VID_WORDS_PER_LINE + x / 4) % `VID_RAM_WORDS;
    return model_ram[word * 4 + x % 4];
endfunction

function automatic logic [11:0] expected_pixel(input int line, input int x);
    logic [7:0] idx1;
    logic [7:0] idx2;
    idx1 = layer_index(0, line, x);
    idx2 = layer_index(1, line, x);
    return model_pal[(idx2 != 8'h00) ? idx2 : idx1];
endfunction

`endif

/* dv/vid_tb.sv */
`timescale 1ns/100ps

`include "vid_defines.svh"

module vid_tb import regbus_pkg::*, video_pkg::*; ();

    localparam int NUM_TESTS   = 6;
    localparam int FRAMES      = 4;
    localparam int LINE_CYCLES = 200;
    localparam int PERIOD      = 20;
    localparam int WATCHDOG_NS = NUM_TESTS * FRAMES * `VID_NUM_LINES * LINE_CYCLES * PERIOD;
    localparam int FRAME_PIX   = `VID_LINE_PIXELS * `VID_NUM_LINES;

    logic      clk;
    logic      reset;
    reg_addr_t reg_addr;
    reg_data_t reg_wrdata;
    logic      reg_strobe;
    logic      reg_write;
    reg_data_t reg_rddata;
    logic      pix_valid;
    rgb_t      pix_rgb;
    logic      frame_start;

    int errors = 0;
    int checks = 0;
    int test_errors;
    int pix_x = 0;
    int pix_line = 0;
    int pix_count = 0;
    logic aligned = 1'b0;

    `include "vid_model.svh"

    vid_top u_vid_top (
        .clk           (clk),
        .reset         (reset),
        .reg_addr_i    (reg_addr),
        .reg_wrdata_i  (reg_wrdata),
        .reg_strobe_i  (reg_strobe),
        .reg_write_i   (reg_write),
        .reg_rddata_o  (reg_rddata),
        .pix_valid_o   (pix_valid),
        .pix_rgb_o     (pix_rgb),
        .frame_start_o (frame_start)
    );

    initial clk = 1'b0;
    always #(PERIOD / 2) clk = ~clk;

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error: %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
        end
    endtask

    ////////////////////////////////////////
    // Bus tasks
    ////////////////////////////////////////

    task automatic bus_write(input logic [11:0] addr, input logic [7:0] data);
        @(posedge clk);
        #2;
        reg_addr   = addr;
        reg_wrdata = data;
        reg_strobe = 1'b1;
        reg_write  = 1'b1;
        @(posedge clk);
        #2;
        reg_strobe = 1'b0;
        reg_write  = 1'b0;
        model_write(addr, data);
    endtask

    // Address is held after the strobe so the data stays put while sampled
    task automatic bus_read_check(input logic [11:0] addr);
        @(posedge clk);
        #2;
        reg_addr   = addr;
        reg_strobe = 1'b1;
        reg_write  = 1'b0;
        @(posedge clk);
        #2;
        reg_strobe = 1'b0;
        check($sformatf("reg_rddata_o[0x%03h]", addr), 32'(reg_rddata), 32'(model_read(addr)));
    endtask

    task automatic set_run(input logic run);
        bus_write(12'h420, {7'b0, run});
    endtask

    task automatic config_layer(input int layer, input logic en, input logic [7:0] base);
        bus_write(12'(12'h400 + 16 * layer), {7'b0, en});
        bus_write(12'(12'h401 + 16 * layer), base);
    endtask

    task automatic fill_ram(input logic sparse);
        logic [7:0] value;
        for (int i = 0; i < 4 * `VID_RAM_WORDS; i++) begin
            value = 8'($urandom);
            if (sparse && ($urandom % 4 != 0)) begin
                value = 8'h00;
            end
            bus_write(12'(i), value);
        end
    endtask

    task automatic fill_palette();
        for (int n = 0; n < `VID_PALETTE_ENTRIES; n++) begin
            bus_write(12'(12'h600 + 2 * n), 8'($urandom));
            bus_write(12'(12'h601 + 2 * n), 8'($urandom));
        end
    endtask

    // Composer is idle once the stream has been quiet longer than a render
    task automatic wait_idle();
        int idle;
        idle = 0;
        while (idle < 150) begin
            @(negedge clk);
            idle = pix_valid ? 0 : idle + 1;
        end
    endtask

    task automatic stream_frames(input int frames, input logic host_reads);
        int target;
        target = pix_count + frames * FRAME_PIX;
        set_run(1'b1);
        while (pix_count < target) begin
            if (host_reads) begin
                bus_read_check(12'($urandom % 1024));
            end else begin
                @(posedge clk);
            end
        end
        set_run(1'b0);
        wait_idle();
    endtask

    task automatic test_done(input int num, input string name);
        $display("Test %0d %s finished with %0d errors", num, name, errors - test_errors);
        test_errors = errors;
    endtask

    ////////////////////////////////////////
    // Pixel monitor
    ////////////////////////////////////////

    always @(negedge clk) begin
        if (!reset && pix_valid) begin
            if (frame_start) begin
                aligned  = 1'b1;
                pix_x    = 0;
                pix_line = 0;
            end
            if (aligned) begin
                check("pix_rgb_o", 32'(pix_rgb), 32'(expected_pixel(pix_line, pix_x)));
                pix_count++;
                pix_x++;
                if (pix_x == `VID_LINE_PIXELS) begin
                    pix_x    = 0;
                    pix_line = (pix_line + 1) % `VID_NUM_LINES;
                end
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before the tests finished");
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        reg_addr    = '0;
        reg_wrdata  = '0;
        reg_strobe  = 1'b0;
        reg_write   = 1'b0;
        reset       = 1'b1;
        test_errors = 0;
        void'($urandom(68));
        repeat (5) @(posedge clk);
        #2;
        reset = 1'b0;

        // Register and RAM readback
        for (int i = 0; i < 4; i++) begin
            bus_write(12'(12'h400 + 16 * (i / 2) + i % 2), 8'($urandom));
            bus_read_check(12'(12'h400 + 16 * (i / 2) + i % 2));
        end
        for (int i = 0; i < 32; i++) begin
            logic [11:0] addr;
            addr = 12'($urandom % 1024);
            bus_write(addr, 8'($urandom));
            bus_read_check(addr);
        end
        bus_read_check(12'h420);
        bus_read_check(12'(12'h600 + $urandom % 512));
        bus_read_check(12'h900);
        test_done(1, "register readback");

        fill_ram(1'b0);
        fill_palette();
        config_layer(0, 1'b1, 8'($urandom));
        config_layer(1, 1'b0, 8'h00);
        stream_frames(2, 1'b0);
        test_done(2, "layer 1 only");

        fill_ram(1'b1);
        fill_palette();
        config_layer(0, 1'b1, 8'($urandom));
        config_layer(1, 1'b1, 8'($urandom));
        stream_frames(2, 1'b0);
        test_done(3, "two layer mix");

        config_layer(0, 1'b0, 8'h00);
        config_layer(1, 1'b0, 8'h00);
        stream_frames(1, 1'b0);
        test_done(4, "both layers disabled");

        config_layer(0, 1'b1, 8'($urandom));
        config_layer(1, 1'b1, 8'($urandom));
        stream_frames(1, 1'b1);
        test_done(5, "host reads while streaming");

        // Stop, stay quiet, then restart at the top of a frame
        stream_frames(1, 1'b0);
        checks++;
        if (pix_x != 0) begin
            errors++;
            $display("Pixel stream stopped inside a line at %0t", $time);
        end
        repeat (300) begin
            @(negedge clk);
            if (pix_valid) begin
                errors++;
                $display("Pixel stream restarted while run was cleared at %0t", $time);
            end
        end
        set_run(1'b1);
        @(negedge clk);
        while (!pix_valid) @(negedge clk);
        check("frame_start_o", 32'(frame_start), 32'h1);
        set_run(1'b0);
        wait_idle();
        test_done(6, "stop and restart");

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* list.f */
+incdir+design
+incdir+dv
design/regbus_pkg.sv
design/video_pkg.sv
design/dp_ram.sv
design/mem_arbiter.sv
design/layer_renderer.sv
design/line_composer.sv
design/vid_top.sv
dv/vid_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the testbench with Verilator, result taken from sim.log
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module vid_tb -f list.f -o vid_sim > build.log 2>&1 &&
./obj_dir/vid_sim > sim.log 2>&1
grep -q "RESULT: PASS" sim.log && echo "simulation passed" || {
    echo "simulation failed, see build.log and sim.log"
    exit 1
}
